// ==== verilog/tiny16_pkg.sv ====
package tiny16_pkg;

    // **************************************************
    // Data types
    // **************************************************
    typedef logic [15:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [6:0]  reg_addr_t;
    typedef logic [4:0]  alu_op_t;

    // Instruction class in opcode bits 7:5
    localparam logic [2:0] CLS_ALU     = 3'd0;
    localparam logic [2:0] CLS_ALUI8   = 3'd1;
    localparam logic [2:0] CLS_ALUI16  = 3'd2;
    localparam logic [2:0] CLS_BR      = 3'd3;
    localparam logic [2:0] CLS_JMP     = 3'd4;
    localparam logic [2:0] CLS_IO      = 3'd5;
    localparam logic [2:0] CLS_SYS     = 3'd6;
    localparam logic [2:0] CLS_ILLEGAL = 3'd7;

    // Sub-codes of the IO and SYS classes
    localparam logic [4:0] IO_OUT   = 5'd0;
    localparam logic [4:0] IO_IN    = 5'd1;
    localparam logic [4:0] SYS_HLT  = 5'd0;
    localparam logic [4:0] SYS_WFI  = 5'd1;
    localparam logic [4:0] SYS_RETI = 5'd2;

    // **************************************************
    // ALU operations
    // **************************************************
    localparam alu_op_t ALU_CLR  = 5'd0;
    localparam alu_op_t ALU_SET  = 5'd1;
    localparam alu_op_t ALU_INC  = 5'd2;
    localparam alu_op_t ALU_DEC  = 5'd3;
    localparam alu_op_t ALU_NOT  = 5'd4;
    localparam alu_op_t ALU_NEG  = 5'd5;
    localparam alu_op_t ALU_SHL  = 5'd6;
    localparam alu_op_t ALU_SHR  = 5'd7;
    localparam alu_op_t ALU_ROL  = 5'd8;
    localparam alu_op_t ALU_ROR  = 5'd9;

    localparam alu_op_t ALU_MOV  = 5'd16;
    localparam alu_op_t ALU_ADC  = 5'd17;
    localparam alu_op_t ALU_ADD  = 5'd18;
    localparam alu_op_t ALU_SBC  = 5'd19;
    localparam alu_op_t ALU_SUB  = 5'd20;
    localparam alu_op_t ALU_AND  = 5'd21;
    localparam alu_op_t ALU_OR   = 5'd22;
    localparam alu_op_t ALU_XOR  = 5'd23;

    localparam alu_op_t ALU_CMP  = 5'd30;
    localparam alu_op_t ALU_TEST = 5'd31;

    // The handler starts just past the 3-byte reset jump
    localparam int unsigned IRQ_VECTOR = 3;

    typedef enum logic [2:0] {
        FETCH,
        OPERAND1,
        OPERAND2,
        EXECUTE,
        IO_WAIT,
        WAIT_IRQ,
        HALTED,
        FAULT
    } ctrl_state_t;

endpackage

// ==== verilog/tiny16_alu.sv ====
`timescale 1ns/1ps

module tiny16_alu (
    input  logic                clk,
    input  logic                nreset,
    input  logic                alu_en,
    input  tiny16_pkg::alu_op_t alu_op,
    input  tiny16_pkg::word_t   operand_a,
    input  tiny16_pkg::word_t   operand_b,
    output tiny16_pkg::word_t   acc,
    output logic                c,
    output logic                z,
    output logic                n
);

    logic carry_in;

    assign carry_in = (alu_op == tiny16_pkg::ALU_ADC || alu_op == tiny16_pkg::ALU_SBC) ? c : 1'b0;

    assign z = (acc == '0);
    assign n = acc[15];

    always_ff @(posedge clk) begin
        if (!nreset) begin
            acc <= '0;
            c   <= 1'b0;
        end else if (alu_en) begin
            case (alu_op)
                // Single-operand ops work on the destination register
                tiny16_pkg::ALU_CLR: acc <= '0;
                tiny16_pkg::ALU_SET: acc <= '1;
                tiny16_pkg::ALU_INC: acc <= operand_a + 16'd1;
                tiny16_pkg::ALU_DEC: acc <= operand_a - 16'd1;
                tiny16_pkg::ALU_NOT: acc <= ~operand_a;
                tiny16_pkg::ALU_NEG: acc <= -operand_a;
                tiny16_pkg::ALU_SHL: {c, acc} <= {operand_a, 1'b0};
                tiny16_pkg::ALU_SHR: {acc, c} <= {1'b0, operand_a};
                tiny16_pkg::ALU_ROL: {c, acc} <= {operand_a, c};   // Rotate through carry
                tiny16_pkg::ALU_ROR: {acc, c} <= {c, operand_a};

                tiny16_pkg::ALU_MOV: acc <= operand_b;
                tiny16_pkg::ALU_ADD, tiny16_pkg::ALU_ADC: begin
                    {c, acc} <= {1'b0, operand_a} + {1'b0, operand_b} + {16'h0, carry_in};
                end
                // Carry holds the borrow after a subtract
                tiny16_pkg::ALU_SUB, tiny16_pkg::ALU_SBC, tiny16_pkg::ALU_CMP: begin
                    {c, acc} <= {1'b0, operand_a} - {1'b0, operand_b} - {16'h0, carry_in};
                end
                tiny16_pkg::ALU_AND, tiny16_pkg::ALU_TEST: acc <= operand_a & operand_b;
                tiny16_pkg::ALU_OR:  acc <= operand_a | operand_b;
                tiny16_pkg::ALU_XOR: acc <= operand_a ^ operand_b;
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== verilog/tiny16_regfile.sv ====
`timescale 1ns/1ps

module tiny16_regfile (
    input  logic                  clk,
    input  tiny16_pkg::reg_addr_t rd_addr_a,
    input  tiny16_pkg::reg_addr_t rd_addr_b,
    output tiny16_pkg::word_t     rd_data_a,
    output tiny16_pkg::word_t     rd_data_b,
    input  logic                  wr_en,
    input  tiny16_pkg::reg_addr_t wr_addr,
    input  tiny16_pkg::word_t     wr_data
);

    tiny16_pkg::word_t regs [0:127];

    // Both read ports are combinational
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// ==== verilog/tiny16_program_mem.sv ====
`timescale 1ns/1ps

module tiny16_program_mem #(
    parameter int RAM_BITS = 13
) (
    input  logic                clk,
    input  logic [RAM_BITS-1:0] fetch_addr,
    output tiny16_pkg::byte_t   fetch_data
);

    tiny16_pkg::byte_t mem [0:(1 << RAM_BITS) - 1];

    initial begin
        $readmemh("test/program.hex", mem);
    end

    always_ff @(posedge clk) begin
        fetch_data <= mem[fetch_addr];   // Byte shows up one cycle after its address
    end

endmodule

// ==== verilog/tiny16_control.sv ====
`timescale 1ns/1ps

module tiny16_control #(
    parameter int RAM_BITS = 13
) (
    input  logic                    clk,
    input  logic                    nreset,
    output logic [RAM_BITS-1:0]     fetch_addr,
    input  tiny16_pkg::byte_t       fetch_data,
    output tiny16_pkg::reg_addr_t   rd_addr_a,
    output tiny16_pkg::reg_addr_t   rd_addr_b,
    input  tiny16_pkg::word_t       rd_data_a,
    input  tiny16_pkg::word_t       rd_data_b,
    output logic                    wr_en,
    output tiny16_pkg::reg_addr_t   wr_addr,
    output tiny16_pkg::word_t       wr_data,
    output logic                    alu_en,
    output tiny16_pkg::alu_op_t     alu_op,
    output tiny16_pkg::word_t       operand_a,
    output tiny16_pkg::word_t       operand_b,
    input  tiny16_pkg::word_t       acc,
    input  logic                    c,
    input  logic                    z,
    input  logic                    n,
    output tiny16_pkg::byte_t       address,
    output tiny16_pkg::word_t       data_out,
    input  tiny16_pkg::word_t       data_in,
    output logic                    mem_valid,
    output logic                    nwr,
    input  logic                    mem_ready,
    input  logic                    interrupt,
    output logic                    in_interrupt,
    output logic                    hlt,
    output logic                    wfi,
    output logic                    error
);

    tiny16_pkg::ctrl_state_t state;

    // pc is the address of the byte now on fetch_data
    logic [RAM_BITS-1:0] pc, saved_pc, next_pc, pc_inc, br_target;
    logic                fetch_ok;
    logic                more;
    logic                wb_pend;

    tiny16_pkg::byte_t opcode, op1;
    tiny16_pkg::word_t imm, br_off, jmp_target;

    logic [2:0] f_cls, cls;
    logic [4:0] f_sub;
    logic       f_bad;
    logic [2:0] cond_hits;
    logic       cond_pass;
    logic       irq_take;
    logic       io_done;

    // **************************************************
    // Decode and branch condition
    // **************************************************
    assign f_cls = fetch_data[7:5];
    assign f_sub = fetch_data[4:0];
    assign cls   = opcode[7:5];

    assign f_bad = (f_cls == tiny16_pkg::CLS_ILLEGAL) ||
                   (f_cls == tiny16_pkg::CLS_SYS && f_sub > tiny16_pkg::SYS_RETI) ||
                   (f_cls == tiny16_pkg::CLS_IO && f_sub > tiny16_pkg::IO_IN);

    assign cond_hits = opcode[2:0] & {c, z, n};
    assign cond_pass = (|cond_hits) ^ opcode[3];

    assign irq_take = fetch_ok && interrupt && !in_interrupt &&
                      (state == tiny16_pkg::FETCH || state == tiny16_pkg::WAIT_IRQ);

    assign pc_inc     = pc + 1'b1;
    assign br_off     = {{8{fetch_data[7]}}, fetch_data};
    assign br_target  = pc_inc + br_off[RAM_BITS-1:0];   // Relative to the next instruction
    assign jmp_target = {op1, fetch_data};

    // The memory reads next_pc, so fetch_data always follows pc
    always_comb begin
        next_pc = pc;
        if (fetch_ok) begin
            case (state)
                tiny16_pkg::FETCH: begin
                    if (irq_take) begin
                        next_pc = RAM_BITS'(tiny16_pkg::IRQ_VECTOR);
                    end else if (f_cls == tiny16_pkg::CLS_SYS && f_sub == tiny16_pkg::SYS_RETI) begin
                        next_pc = saved_pc;
                    end else begin
                        next_pc = pc_inc;
                    end
                end
                tiny16_pkg::OPERAND1: begin
                    next_pc = (cls == tiny16_pkg::CLS_BR && cond_pass) ? br_target : pc_inc;
                end
                tiny16_pkg::OPERAND2: begin
                    next_pc = (cls == tiny16_pkg::CLS_JMP) ? jmp_target[RAM_BITS-1:0] : pc_inc;
                end
                tiny16_pkg::WAIT_IRQ: begin
                    if (irq_take) begin
                        next_pc = RAM_BITS'(tiny16_pkg::IRQ_VECTOR);
                    end
                end
                default: begin
                end
            endcase
        end
    end

    assign fetch_addr = next_pc;

    // **************************************************
    // Sequencer
    // **************************************************
    always_ff @(posedge clk) begin
        if (!nreset) begin
            state        <= tiny16_pkg::FETCH;
            fetch_ok     <= 1'b0;
            pc           <= '0;
            opcode       <= '0;
            more         <= 1'b0;
            wb_pend      <= 1'b0;
            in_interrupt <= 1'b0;
            hlt          <= 1'b0;
            wfi          <= 1'b0;
            error        <= 1'b0;
        end else begin
            fetch_ok <= 1'b1;   // First cycle only brings address 0 out of the memory
            pc       <= next_pc;
            wb_pend  <= 1'b0;
            if (irq_take) begin
                saved_pc     <= pc;
                in_interrupt <= 1'b1;
            end
            case (state)
                tiny16_pkg::FETCH: begin
                    if (fetch_ok && !irq_take) begin
                        opcode <= fetch_data;
                        if (f_bad) begin
                            error <= 1'b1;
                            state <= tiny16_pkg::FAULT;
                        end else if (f_cls == tiny16_pkg::CLS_SYS) begin
                            if (f_sub == tiny16_pkg::SYS_HLT) begin
                                hlt   <= 1'b1;
                                state <= tiny16_pkg::HALTED;
                            end else if (f_sub == tiny16_pkg::SYS_WFI) begin
                                wfi   <= 1'b1;
                                state <= tiny16_pkg::WAIT_IRQ;
                            end else begin
                                in_interrupt <= 1'b0;   // RETI
                            end
                        end else begin
                            state <= tiny16_pkg::OPERAND1;
                        end
                    end
                end
                tiny16_pkg::OPERAND1: begin
                    op1   <= fetch_data;
                    more  <= (cls == tiny16_pkg::CLS_ALUI16);
                    state <= (cls == tiny16_pkg::CLS_BR) ? tiny16_pkg::FETCH : tiny16_pkg::OPERAND2;
                end
                tiny16_pkg::OPERAND2: begin
                    imm  <= {imm[7:0], fetch_data};   // High byte arrives first
                    more <= 1'b0;
                    if (!more) begin
                        case (cls)
                            tiny16_pkg::CLS_IO:  state <= tiny16_pkg::IO_WAIT;
                            tiny16_pkg::CLS_JMP: state <= tiny16_pkg::FETCH;
                            default:             state <= tiny16_pkg::EXECUTE;
                        endcase
                    end
                end
                tiny16_pkg::EXECUTE: begin
                    wb_pend <= (alu_op != tiny16_pkg::ALU_CMP) && (alu_op != tiny16_pkg::ALU_TEST);
                    state   <= tiny16_pkg::FETCH;
                end
                tiny16_pkg::IO_WAIT: begin
                    if (mem_ready) begin
                        state <= tiny16_pkg::FETCH;
                    end
                end
                tiny16_pkg::WAIT_IRQ: begin
                    if (interrupt) begin
                        wfi   <= 1'b0;
                        state <= tiny16_pkg::FETCH;
                    end
                end
                default: begin   // HALTED and FAULT hold until reset
                end
            endcase
        end
    end

    // **************************************************
    // Datapath steering and I/O bus
    // **************************************************
    assign rd_addr_a = op1[6:0];
    assign rd_addr_b = imm[6:0];

    assign alu_en    = (state == tiny16_pkg::EXECUTE);
    assign alu_op    = opcode[4:0];
    assign operand_a = rd_data_a;

    always_comb begin
        case (cls)
            tiny16_pkg::CLS_ALUI8:  operand_b = {{8{imm[7]}}, imm[7:0]};
            tiny16_pkg::CLS_ALUI16: operand_b = imm;
            default:                operand_b = rd_data_b;
        endcase
    end

    assign mem_valid = (state == tiny16_pkg::IO_WAIT);
    assign io_done   = mem_valid && mem_ready;
    assign nwr       = (opcode[4:0] != tiny16_pkg::IO_OUT);
    assign address   = imm[7:0];
    assign data_out  = rd_data_a;

    // ALU results land the cycle after EXECUTE, IN data in the completing cycle
    assign wr_en   = wb_pend || (io_done && opcode[4:0] == tiny16_pkg::IO_IN);
    assign wr_addr = op1[6:0];
    assign wr_data = wb_pend ? acc : data_in;

endmodule

// ==== verilog/tiny16.sv ====
`timescale 1ns/1ps

module tiny16 #(
    parameter int RAM_BITS = 13
) (
    input  logic              clk,
    input  logic              nreset,
    output logic              error,
    output logic              hlt,
    output logic              wfi,
    output tiny16_pkg::byte_t address,
    input  tiny16_pkg::word_t data_in,
    output tiny16_pkg::word_t data_out,
    output logic              mem_valid,
    output logic              nwr,
    input  logic              mem_ready,
    input  logic              interrupt,
    output logic              in_interrupt
);

    logic [RAM_BITS-1:0]   fetch_addr;
    tiny16_pkg::byte_t     fetch_data;
    tiny16_pkg::reg_addr_t rd_addr_a, rd_addr_b, wr_addr;
    tiny16_pkg::word_t     rd_data_a, rd_data_b, wr_data;
    logic                  wr_en;
    logic                  alu_en;
    tiny16_pkg::alu_op_t   alu_op;
    tiny16_pkg::word_t     operand_a, operand_b, acc;
    logic                  c, z, n;

    tiny16_control #(
        .RAM_BITS (RAM_BITS)
    ) i_control (
        .clk          (clk),
        .nreset       (nreset),
        .fetch_addr   (fetch_addr),
        .fetch_data   (fetch_data),
        .rd_addr_a    (rd_addr_a),
        .rd_addr_b    (rd_addr_b),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .alu_en       (alu_en),
        .alu_op       (alu_op),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .acc          (acc),
        .c            (c),
        .z            (z),
        .n            (n),
        .address      (address),
        .data_out     (data_out),
        .data_in      (data_in),
        .mem_valid    (mem_valid),
        .nwr          (nwr),
        .mem_ready    (mem_ready),
        .interrupt    (interrupt),
        .in_interrupt (in_interrupt),
        .hlt          (hlt),
        .wfi          (wfi),
        .error        (error)
    );

    tiny16_alu i_alu (
        .clk       (clk),
        .nreset    (nreset),
        .alu_en    (alu_en),
        .alu_op    (alu_op),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .acc       (acc),
        .c         (c),
        .z         (z),
        .n         (n)
    );

    tiny16_regfile i_regfile (
        .clk       (clk),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    tiny16_program_mem #(
        .RAM_BITS (RAM_BITS)
    ) i_program_mem (
        .clk        (clk),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data)
    );

endmodule

// ==== test/tiny16_assert.sv ====
`timescale 1ns/1ps

module tiny16_assert (
    input logic              clk,
    input logic              nreset,
    input logic              mem_valid,
    input logic              mem_ready,
    input logic              nwr,
    input logic              hlt,
    input logic              error,
    input tiny16_pkg::byte_t address,
    input tiny16_pkg::word_t data_out
);

    // A pending transfer holds its strobe, address and data
    a_bus_stable: assert property (@(posedge clk) disable iff (!nreset)
        (mem_valid && !mem_ready) |=>
            (mem_valid && $stable(address) && $stable(nwr) && $stable(data_out)))
        else $error("I/O bus changed while a transfer was pending");

    a_reset_clear: assert property (@(posedge clk)
        !nreset |=> (!mem_valid && !hlt && !error))
        else $error("mem_valid, hlt or error high after reset");

    a_hlt_error: assert property (@(posedge clk) disable iff (!nreset) !(hlt && error))
        else $error("hlt and error high together");

endmodule

bind tiny16_control tiny16_assert i_assert (
    .clk       (clk),
    .nreset    (nreset),
    .mem_valid (mem_valid),
    .mem_ready (mem_ready),
    .nwr       (nwr),
    .hlt       (hlt),
    .error     (error),
    .address   (address),
    .data_out  (data_out)
);

// ==== test/tiny16_tb.sv ====
`timescale 1ns/1ps

module tiny16_tb;

    localparam int MAX_CYCLES = 5000;
    localparam int DRAIN_CYCLES = 20;
    localparam int OUT_COUNT = 25;   // 16 ALU results, 1 input sum, 5 counts, 2 markers, 1 post-IRQ

    logic              clk;
    logic              nreset;
    logic              error;
    logic              hlt;
    logic              wfi;
    logic              mem_valid;
    logic              nwr;
    logic              mem_ready;
    logic              interrupt;
    logic              in_interrupt;
    tiny16_pkg::byte_t address;
    tiny16_pkg::word_t data_in;
    tiny16_pkg::word_t data_out;

    integer seed = 97103;
    int     n_errors;
    int     n_checks;
    int     n_out;
    logic   irq_seen;

    logic [23:0]       out_q [$];   // Completed OUT transfers as {address, data_out}
    tiny16_pkg::byte_t exp_port [$];
    tiny16_pkg::word_t exp_data [$];
    tiny16_pkg::word_t in_rec [0:255];   // Last IN value per port

    tiny16 #(
        .RAM_BITS (13)
    ) i_dut (
        .clk          (clk),
        .nreset       (nreset),
        .error        (error),
        .hlt          (hlt),
        .wfi          (wfi),
        .address      (address),
        .data_in      (data_in),
        .data_out     (data_out),
        .mem_valid    (mem_valid),
        .nwr          (nwr),
        .mem_ready    (mem_ready),
        .interrupt    (interrupt),
        .in_interrupt (in_interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // **************************************************
    // Reference model
    // **************************************************

    // Returns {carry, result}
    function automatic logic [16:0] ref_alu(input tiny16_pkg::alu_op_t op,
                                            input tiny16_pkg::word_t a,
                                            input tiny16_pkg::word_t b,
                                            input logic cin);
        logic [16:0] wide;
        case (op)
            tiny16_pkg::ALU_CLR:  return {cin, 16'h0000};
            tiny16_pkg::ALU_SET:  return {cin, 16'hffff};
            tiny16_pkg::ALU_INC:  return {cin, a + 16'h0001};
            tiny16_pkg::ALU_DEC:  return {cin, a - 16'h0001};
            tiny16_pkg::ALU_NOT:  return {cin, ~a};
            tiny16_pkg::ALU_NEG:  return {cin, 16'h0000 - a};
            tiny16_pkg::ALU_SHL:  return {a[15], a[14:0], 1'b0};
            tiny16_pkg::ALU_SHR:  return {a[0], 1'b0, a[15:1]};
            tiny16_pkg::ALU_ROL:  return {a[15], a[14:0], cin};
            tiny16_pkg::ALU_ROR:  return {a[0], cin, a[15:1]};
            tiny16_pkg::ALU_MOV:  return {cin, b};
            tiny16_pkg::ALU_ADD:  return {1'b0, a} + {1'b0, b};
            tiny16_pkg::ALU_ADC:  return {1'b0, a} + {1'b0, b} + 17'(cin);
            tiny16_pkg::ALU_AND:  return {cin, a & b};
            tiny16_pkg::ALU_OR:   return {cin, a | b};
            tiny16_pkg::ALU_XOR:  return {cin, a ^ b};
            tiny16_pkg::ALU_SUB, tiny16_pkg::ALU_SBC: begin
                // Borrow ends up in bit 16
                wide = {1'b0, a} - {1'b0, b};
                if (op == tiny16_pkg::ALU_SBC) begin
                    wide = wide - 17'(cin);
                end
                return wide;
            end
            default: return {cin, a};
        endcase
    endfunction

    task automatic add_expect(input tiny16_pkg::byte_t port, input tiny16_pkg::word_t value);
        exp_port.push_back(port);
        exp_data.push_back(value);
    endtask

    // Mirrors the sequence in program.hex
    task automatic build_expected();
        tiny16_pkg::alu_op_t op_seq [0:14];
        tiny16_pkg::word_t   r1;
        tiny16_pkg::word_t   r2;
        tiny16_pkg::word_t   r3;
        tiny16_pkg::word_t   b;
        logic                c_m;
        logic [16:0]         res;
        op_seq = '{tiny16_pkg::ALU_ADD, tiny16_pkg::ALU_ADC, tiny16_pkg::ALU_SUB,
                   tiny16_pkg::ALU_SBC, tiny16_pkg::ALU_AND, tiny16_pkg::ALU_OR,
                   tiny16_pkg::ALU_XOR, tiny16_pkg::ALU_NOT, tiny16_pkg::ALU_NEG,
                   tiny16_pkg::ALU_INC, tiny16_pkg::ALU_DEC, tiny16_pkg::ALU_SHL,
                   tiny16_pkg::ALU_SHR, tiny16_pkg::ALU_ROL, tiny16_pkg::ALU_ROR};
        r1  = 16'h1234;
        r2  = 16'hf00f;
        r3  = 16'hff85;   // 0x85 sign-extended
        c_m = 1'b0;
        for (int i = 0; i < 15; i++) begin
            b   = (i % 2 == 0) ? r2 : r3;
            res = ref_alu(op_seq[i], r1, b, c_m);
            r1  = res[15:0];
            c_m = res[16];
            add_expect(8'(i + 1), r1);
        end
        add_expect(8'h10, r3);
        add_expect(8'h41, 16'h0000);   // Filled in from the recorded IN value
        for (int k = 5; k >= 1; k--) begin
            add_expect(8'h50, 16'(k));
        end
        add_expect(8'h51, 16'haa55);
        add_expect(8'hf0, 16'hbeef);
        add_expect(8'h60, 16'h007e);
    endtask

    // **************************************************
    // Checks
    // **************************************************
    task automatic check_word(input string name, input tiny16_pkg::word_t expected,
                              input tiny16_pkg::word_t actual);
        n_checks++;
        if (actual !== expected) begin
            $display("mismatch %s: expected %04h, actual %04h", name, expected, actual);
            n_errors++;
        end
    endtask

    task automatic check_byte(input string name, input tiny16_pkg::byte_t expected,
                              input tiny16_pkg::byte_t actual);
        n_checks++;
        if (actual !== expected) begin
            $display("mismatch %s: expected %02h, actual %02h", name, expected, actual);
            n_errors++;
        end
    endtask

    // I/O device with random back-pressure
    initial begin : device
        int   delay;
        logic active;
        active = 1'b0;
        delay  = 0;
        forever begin
            @(posedge clk);
            #2;
            if (mem_ready) begin
                mem_ready = 1'b0;   // Transfer completed at this edge
            end else if (mem_valid) begin
                if (!active) begin
                    active = 1'b1;
                    delay  = $unsigned($random(seed)) % 4;
                end
                if (delay == 0) begin
                    active    = 1'b0;
                    mem_ready = 1'b1;
                    if (!nwr) begin
                        out_q.push_back({address, data_out});
                    end else begin
                        data_in          = 16'($random(seed));
                        in_rec[address]  = data_in;
                    end
                end else begin
                    delay--;
                end
            end
        end
    end

    initial begin : irq_driver
        forever begin
            @(posedge clk);
            #2;
            if (in_interrupt) begin
                if (interrupt) begin
                    interrupt = 1'b0;
                    irq_seen  = 1'b1;
                end
            end else if (wfi && !irq_seen) begin
                interrupt = 1'b1;
            end
        end
    end

    initial begin : compare
        logic [23:0]       entry;
        tiny16_pkg::byte_t port;
        tiny16_pkg::word_t expected;
        forever begin
            @(posedge clk);
            if (out_q.size() > 0) begin
                entry = out_q.pop_front();
                n_out++;
                if (exp_port.size() == 0) begin
                    $display("unexpected OUT transfer to port %02h", entry[23:16]);
                    n_errors++;
                end else begin
                    port     = exp_port.pop_front();
                    expected = exp_data.pop_front();
                    if (port == 8'h41) begin
                        expected = in_rec[8'h40] + 16'h0025;
                    end
                    check_byte($sformatf("out %0d address", n_out), port, entry[23:16]);
                    check_word($sformatf("out %0d port %02h", n_out, port), expected,
                               entry[15:0]);
                end
            end
        end
    end

    // **************************************************
    // Main sequence
    // **************************************************
    initial begin : main
        int cycles;
        nreset    = 1'b0;
        mem_ready = 1'b0;
        data_in   = '0;
        interrupt = 1'b0;
        n_errors  = 0;
        n_checks  = 0;
        n_out     = 0;
        irq_seen  = 1'b0;
        build_expected();
        repeat (5) @(posedge clk);
        #2;
        nreset = 1'b1;

        cycles = 0;
        while (hlt !== 1'b1 && cycles < MAX_CYCLES) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (hlt !== 1'b1) begin
            $display("timeout: hlt did not rise within %0d cycles", MAX_CYCLES);
            n_errors++;
        end

        cycles = 0;
        while (out_q.size() > 0 && cycles < DRAIN_CYCLES) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (out_q.size() > 0) begin
            $display("timeout: %0d OUT transfers were never compared", out_q.size());
            n_errors++;
        end

        if (n_out != OUT_COUNT) begin
            $display("wrong number of OUT transfers: %0d seen, %0d expected", n_out, OUT_COUNT);
            n_errors++;
        end
        if (error !== 1'b0) begin
            $display("error output went high during the run");
            n_errors++;
        end
        if (!irq_seen) begin
            $display("in_interrupt never rose after the interrupt request");
            n_errors++;
        end
        if (in_interrupt !== 1'b0) begin
            $display("in_interrupt still high at the end, RETI did not clear it");
            n_errors++;
        end
        if (wfi !== 1'b0) begin
            $display("wfi still high at the end, the interrupt did not clear it");
            n_errors++;
        end

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== test/program.hex ====
// Instruction bytes in hex, one instruction per line from address 0
// Opcode first, then its operand bytes, then the mnemonic
80 00 0b     // 00: JMP 0x000b
50 14 be ef  // 03: handler, MOV r20, #0xbeef
a0 14 f0     // 07: OUT r20 -> 0xf0
c2           // 0a: RETI
50 01 12 34  // 0b: MOV r1, #0x1234
50 02 f0 0f  // 0f: MOV r2, #0xf00f
30 03 85     // 13: MOV r3, #0x85
12 01 02     // ADD r1, r2
a0 01 01
11 01 03     // ADC r1, r3
a0 01 02
14 01 02     // SUB r1, r2
a0 01 03
13 01 03     // SBC r1, r3
a0 01 04
15 01 02     // AND r1, r2
a0 01 05
16 01 03     // OR r1, r3
a0 01 06
17 01 02     // XOR r1, r2
a0 01 07
04 01 00     // NOT r1
a0 01 08
05 01 00     // NEG r1
a0 01 09
02 01 00     // INC r1
a0 01 0a
03 01 00     // DEC r1
a0 01 0b
06 01 00     // SHL r1
a0 01 0c
07 01 00     // SHR r1
a0 01 0d
08 01 00     // ROL r1
a0 01 0e
09 01 00     // ROR r1
a0 01 0f
a0 03 10     // 70: OUT r3 -> 0x10
a1 04 40     // 73: IN r4 <- 0x40
32 04 25     // 76: ADD r4, #0x25
a0 04 41     // 79: OUT r4 -> 0x41
30 05 05     // 7c: MOV r5, #5
a0 05 50     // 7f: loop, OUT r5 -> 0x50
03 05 00     // 82: DEC r5
6a f8        // 85: BR nz, loop
50 07 aa 55  // 87: MOV r7, #0xaa55
30 06 07     // 8b: MOV r6, #7
3e 06 03     // 8e: CMP r6, #3
62 03        // 91: BR z, +3 (not taken)
a0 07 51     // 93: OUT r7 -> 0x51
c1           // 96: WFI
30 08 7e     // 97: MOV r8, #0x7e
a0 08 60     // 9a: OUT r8 -> 0x60
c0           // 9d: HLT

// ==== src.f ====
verilog/tiny16_pkg.sv
verilog/tiny16_alu.sv
verilog/tiny16_regfile.sv
verilog/tiny16_program_mem.sv
verilog/tiny16_control.sv
verilog/tiny16.sv
test/tiny16_assert.sv
test/tiny16_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the tiny16 testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tiny16_tb \
    -f src.f \
    -o tiny16_sim

./obj_dir/tiny16_sim | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"
